/* design/disp_pkg.sv */
// display geometry types
// default 640x480 timing values and star-field size

`default_nettype none

package disp_pkg;

    // screen position, also used for line and pixel counts
    typedef logic [15:0] coord_t;

    // horizontal timing in pixels
    localparam coord_t H_ACTIVE_DEF = 16'd640;
    localparam coord_t H_FP_DEF     = 16'd16;   // front porch
    localparam coord_t H_SYNC_DEF   = 16'd96;
    localparam coord_t H_BP_DEF     = 16'd48;   // back porch

    // vertical timing in lines
    localparam coord_t V_ACTIVE_DEF = 16'd480;
    localparam coord_t V_FP_DEF     = 16'd10;
    localparam coord_t V_SYNC_DEF   = 16'd2;
    localparam coord_t V_BP_DEF     = 16'd33;

    // star field sits at the top-left corner of the screen
    localparam coord_t FIELD_W_DEF  = 16'd512;
    localparam coord_t FIELD_H_DEF  = 16'd256;

endpackage

`default_nettype wire

/* design/star_pkg.sv */
// LFSR state, colour channel and density types
// LFSR width, seed and star-test constants

`default_nettype none

package star_pkg;

    localparam int LFSR_W  = 17;    // LFSR length
    localparam int COLOR_W = 4;     // bits per colour channel

    typedef logic [LFSR_W-1:0]  lfsr_t;
    typedef logic [COLOR_W-1:0] color_t;

    // density select, star needs STAR_BITS_MIN + density top bits set
    typedef logic [1:0] density_t;

    // fewest top bits tested at density 0
    localparam int STAR_BITS_MIN = 6;

    // reload value at each frame start, never zero
    localparam lfsr_t LFSR_SEED_DEF = 17'h1FFFF;

endpackage

`default_nettype wire

/* design/display_timing.sv */
// display timing generator
// pixel and line counters, sync, data enable, frame pulse, field step strobe

`default_nettype none
`timescale 1ns/1ps

module display_timing import disp_pkg::*; #(
    parameter coord_t H_ACTIVE = H_ACTIVE_DEF,
    parameter coord_t H_FP     = H_FP_DEF,
    parameter coord_t H_SYNC   = H_SYNC_DEF,
    parameter coord_t H_BP     = H_BP_DEF,
    parameter coord_t V_ACTIVE = V_ACTIVE_DEF,
    parameter coord_t V_FP     = V_FP_DEF,
    parameter coord_t V_SYNC   = V_SYNC_DEF,
    parameter coord_t V_BP     = V_BP_DEF,
    parameter coord_t FIELD_W  = FIELD_W_DEF,
    parameter coord_t FIELD_H  = FIELD_H_DEF
) (
    input  wire logic   clk_pix,
    input  wire logic   rst_n,
    output      coord_t sx,         // pixel position in line
    output      coord_t sy,         // line position in frame
    output      logic   hsync,      // active low
    output      logic   vsync,      // active low
    output      logic   de,         // active area
    output      logic   frame,      // first pixel of frame
    output      logic   step        // pixel inside star field
);

    // horizontal boundaries
    localparam coord_t H_SYNC_START = H_ACTIVE + H_FP;
    localparam coord_t H_SYNC_END   = H_SYNC_START + H_SYNC;   // first pixel after sync
    localparam coord_t H_TOTAL      = H_SYNC_END + H_BP;

    // vertical boundaries
    localparam coord_t V_SYNC_START = V_ACTIVE + V_FP;
    localparam coord_t V_SYNC_END   = V_SYNC_START + V_SYNC;
    localparam coord_t V_TOTAL      = V_SYNC_END + V_BP;

    logic line_end;     // last pixel of a line
    logic frame_end;    // last line of a frame

    assign line_end  = (sx == H_TOTAL - 16'd1);
    assign frame_end = (sy == V_TOTAL - 16'd1);

    // position counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;   // wrap at line total
            if (frame_end) begin
                sy <= '0;
            end else begin
                sy <= sy + 16'd1;
            end
        end else begin
            sx <= sx + 16'd1;
        end
    end

    // decoded in the same cycle as the counters
    always_comb begin
        hsync = !((sx >= H_SYNC_START) && (sx < H_SYNC_END));
        vsync = !((sy >= V_SYNC_START) && (sy < V_SYNC_END));
        de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        frame = (sx == '0) && (sy == '0);
        step  = de && (sx < FIELD_W) && (sy < FIELD_H);   // field at top-left
    end

endmodule

`default_nettype wire

/* design/star_lfsr.sv */
// star LFSR
// 17-bit Fibonacci shift register, seed reload per frame, advance on step

`default_nettype none
`timescale 1ns/1ps

module star_lfsr import star_pkg::*; #(
    parameter lfsr_t SEED = LFSR_SEED_DEF   // must be nonzero
) (
    input  wire logic  clk_pix,
    input  wire logic  rst_n,
    input  wire logic  frame,   // frame start, reload seed
    input  wire logic  step,    // advance one position
    output      lfsr_t state    // value seen by the current pixel
);

    // feedback taps, new bit 0 is bit 16 xor bit 13
    localparam int TAP_A = 16;
    localparam int TAP_B = 13;

    lfsr_t sreg;        // held value between steps
    lfsr_t next_state;

    // seed shows through on the frame cycle
    assign state = frame ? SEED : sreg;

    // left shift with xor feedback into bit 0
    assign next_state = {state[LFSR_W-2:0], state[TAP_A] ^ state[TAP_B]};

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sreg <= SEED;
        end else if (step) begin
            sreg <= next_state;     // k-th field pixel sees S_k
        end
    end

endmodule

`default_nettype wire

/* design/star_shader.sv */
// star shader
// density mask, star decision, registered sync, data enable and grey RGB

`default_nettype none
`timescale 1ns/1ps

module star_shader import star_pkg::*; (
    input  wire logic     clk_pix,
    input  wire logic     rst_n,
    input  wire logic     step,         // pixel inside the field
    input  wire logic     de,
    input  wire logic     hsync,
    input  wire logic     vsync,
    input  wire lfsr_t    state,        // LFSR value for this pixel
    input  wire logic     field_en,     // stars on
    input  wire density_t density,      // top bits tested, 6 plus this
    output      logic     vga_hsync,
    output      logic     vga_vsync,
    output      logic     vga_de,
    output      color_t   vga_r,
    output      color_t   vga_g,
    output      color_t   vga_b
);

    lfsr_t  mask;       // selected top bits of state
    logic   star;
    color_t grey;       // brightness for all three channels

    // ones from bit 16 downward, 6 to 9 of them
    assign mask = ~(lfsr_t'('1) >> (STAR_BITS_MIN + int'(density)));

    // one AND test against the mask
    assign star = step && field_en && ((state & mask) == mask);
    assign grey = star ? state[COLOR_W-1:0] : '0;

    // one register stage keeps sync, de and colour aligned
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;      // inactive
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            vga_de    <= de;
            vga_r     <= grey;
            vga_g     <= grey;
            vga_b     <= grey;
        end
    end

endmodule

`default_nettype wire

/* design/starfield_top.sv */
// starfield top level
// timing generator, star LFSR and shader with shared parameters

`default_nettype none
`timescale 1ns/1ps

module starfield_top import disp_pkg::*, star_pkg::*; #(
    parameter coord_t H_ACTIVE = H_ACTIVE_DEF,
    parameter coord_t H_FP     = H_FP_DEF,
    parameter coord_t H_SYNC   = H_SYNC_DEF,
    parameter coord_t H_BP     = H_BP_DEF,
    parameter coord_t V_ACTIVE = V_ACTIVE_DEF,
    parameter coord_t V_FP     = V_FP_DEF,
    parameter coord_t V_SYNC   = V_SYNC_DEF,
    parameter coord_t V_BP     = V_BP_DEF,
    parameter coord_t FIELD_W  = FIELD_W_DEF,
    parameter coord_t FIELD_H  = FIELD_H_DEF,
    parameter lfsr_t  SEED     = LFSR_SEED_DEF
) (
    input  wire logic     clk_pix,
    input  wire logic     rst_n,
    input  wire logic     field_en,
    input  wire density_t density,
    output      logic     vga_hsync,
    output      logic     vga_vsync,
    output      logic     vga_de,
    output      color_t   vga_r,
    output      color_t   vga_g,
    output      color_t   vga_b
);

    logic   hsync;
    logic   vsync;
    logic   de;
    logic   frame;
    logic   step;
    lfsr_t  state;

    display_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP),
        .FIELD_W  (FIELD_W),
        .FIELD_H  (FIELD_H)
    ) display_timing_i (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (),
        .sy      (),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame),
        .step    (step)
    );

    star_lfsr #(
        .SEED (SEED)
    ) star_lfsr_i (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .frame   (frame),
        .step    (step),
        .state   (state)
    );

    star_shader star_shader_i (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .step      (step),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync),
        .state     (state),
        .field_en  (field_en),
        .density   (density),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

/* testbench/starfield_chk.sv */
// bound assertions for the starfield top level
// blanking, hsync width, LFSR lockup, reset levels

`default_nettype none
`timescale 1ns/1ps

module starfield_chk import disp_pkg::*, star_pkg::*; #(
    parameter coord_t H_SYNC = H_SYNC_DEF
) (
    input wire logic   clk_pix,
    input wire logic   rst_n,
    input wire logic   vga_hsync,
    input wire logic   vga_vsync,
    input wire logic   vga_de,
    input wire color_t vga_r,
    input wire color_t vga_g,
    input wire color_t vga_b,
    input wire lfsr_t  state
);

    int fail_cnt;   // failed assertions so far

    // blanked outside the active area
    blank_colour: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !vga_de |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
        else begin
            $error("colour output nonzero while vga_de low");
            fail_cnt++;
        end

    // hsync pulse width in pixels
    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(vga_hsync) |-> !vga_hsync [*H_SYNC] ##1 vga_hsync)
        else begin
            $error("hsync pulse width differs from H_SYNC");
            fail_cnt++;
        end

    lfsr_nonzero: assert property (@(posedge clk_pix) disable iff (!rst_n)
        state != '0)
        else begin
            $error("LFSR state reached zero");
            fail_cnt++;
        end

    // async reset forces inactive levels
    reset_levels: assert property (@(posedge clk_pix)
        !rst_n |-> (!vga_de && vga_hsync && vga_vsync))
        else begin
            $error("outputs not inactive during reset");
            fail_cnt++;
        end

endmodule

bind starfield_top starfield_chk #(.H_SYNC(H_SYNC)) starfield_chk_i (
    .clk_pix   (clk_pix),
    .rst_n     (rst_n),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .state     (state)
);

`default_nettype wire

/* testbench/starfield_tb.sv */
// starfield testbench
// small video mode, file-driven records, frame capture and compare tasks

`default_nettype none
`timescale 1ns/1ps

module starfield_tb import disp_pkg::*, star_pkg::*; ();

    localparam int NUM_TESTS = 5;
    localparam int NUM_PTS   = 8;
    localparam int REC_W     = 5 + 3*NUM_PTS;   // words per record
    localparam int H_ACT     = 32;
    localparam int V_ACT     = 16;
    localparam int H_TOT     = 40;
    localparam int FIELD_W   = 24;
    localparam int FIELD_H   = 8;
    localparam int FRAME     = 800;     // 40 x 20 cycles

    logic     clk_pix;
    logic     rst_n;
    logic     field_en;
    density_t density;
    logic     vga_hsync;
    logic     vga_vsync;
    logic     vga_de;
    color_t   vga_r;
    color_t   vga_g;
    color_t   vga_b;

    logic [7:0] tests_mem [0:NUM_TESTS*REC_W-1];
    color_t     pix [0:H_ACT*V_ACT-1];        // captured frame, raster order
    color_t     prev_pix [0:H_ACT*V_ACT-1];
    coord_t     hs_cnt;
    coord_t     line_cnt;
    coord_t     bad_lines;     // lines not H_ACT long
    coord_t     de_total;
    int         errors;
    int         passes;
    int         fails;
    int         cycles;
    int         limit;

    starfield_top #(
        .H_ACTIVE (16'd32),
        .H_FP     (16'd2),
        .H_SYNC   (16'd4),
        .H_BP     (16'd2),
        .V_ACTIVE (16'd16),
        .V_FP     (16'd1),
        .V_SYNC   (16'd2),
        .V_BP     (16'd1),
        .FIELD_W  (16'd24),
        .FIELD_H  (16'd8)
    ) starfield_top_i (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .field_en  (field_en),
        .density   (density),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    always #10 clk_pix = ~clk_pix;     // 20 ns period

    // run limit
    always @(posedge clk_pix) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run passed %0d cycles without finishing", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_color(input string what, input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
            errors++;
        end
    endtask

    task automatic check_coord(input string what, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
            errors++;
        end
    endtask

    // returns on the first sample after vga_vsync rises
    task automatic wait_vsync_end();
        logic vs_prev;
        vs_prev = vga_vsync;
        @(negedge clk_pix);
        while (vs_prev || !vga_vsync) begin
            vs_prev = vga_vsync;
            @(negedge clk_pix);
        end
    endtask

    // one frame from end of vsync to the next end of vsync
    task automatic capture_frame();
        logic   vs_prev;
        logic   hs_prev;
        logic   de_prev;
        coord_t run;
        int     idx;
        wait_vsync_end();
        hs_cnt = '0;
        line_cnt = '0;
        bad_lines = '0;
        run = '0;
        idx = 0;
        hs_prev = vga_hsync;
        de_prev = 1'b0;
        do begin
            if (hs_prev && !vga_hsync) hs_cnt++;     // falling edge
            if (vga_de) begin
                if (idx < H_ACT*V_ACT) pix[idx] = vga_r;
                check_color("vga_g vs vga_r", vga_g, vga_r);   // grey
                check_color("vga_b vs vga_r", vga_b, vga_r);
                idx++;
                run++;
            end else if (de_prev) begin
                line_cnt++;
                if (run != H_ACT) bad_lines++;
                run = '0;
            end
            hs_prev = vga_hsync;
            de_prev = vga_de;
            vs_prev = vga_vsync;
            @(negedge clk_pix);
        end while (vs_prev || !vga_vsync);
        de_total = coord_t'(idx);
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: pass", name);
            passes++;
        end else begin
            $display("test %s: FAIL", name);
            fails++;
        end
    endtask

    task automatic run_record(input int rec);
        int     base;
        int     errs_before;
        coord_t lit;
        coord_t outside;
        int     x;
        int     y;
        base = rec * REC_W;
        errs_before = errors;
        @(posedge clk_pix);
        density  <= density_t'(tests_mem[base+1]);
        field_en <= tests_mem[base+2][0];
        repeat (FRAME) @(posedge clk_pix);    // settle one full frame
        capture_frame();
        lit = '0;
        outside = '0;
        for (int i = 0; i < H_ACT*V_ACT; i++) begin
            if ((i % H_ACT) < FIELD_W && (i / H_ACT) < FIELD_H) begin
                if (pix[i] != '0) lit++;
            end else if (pix[i] != '0) begin
                outside++;
            end
        end
        check_coord("lit count", lit, coord_t'(tests_mem[base+3]));
        check_coord("pixels outside field", outside, '0);
        check_coord("de pixels", de_total, coord_t'(H_ACT*V_ACT));
        check_coord("active lines", line_cnt, coord_t'(V_ACT));
        check_coord("lines of wrong length", bad_lines, '0);
        check_coord("hsync pulses", hs_cnt, 16'd20);
        for (int p = 0; p < tests_mem[base+4]; p++) begin
            x = tests_mem[base+5+3*p];
            y = tests_mem[base+6+3*p];
            check_color($sformatf("vga_r at (%0d,%0d)", x, y), pix[y*H_ACT+x],
                        color_t'(tests_mem[base+7+3*p]));
        end
        report($sformatf("%0d density %0d field_en %0d", tests_mem[base],
               tests_mem[base+1], tests_mem[base+2]), errs_before);
    endtask

    // same settings, next frame must be identical
    task automatic repeat_frame();
        int     errs_before;
        coord_t diff;
        errs_before = errors;
        for (int i = 0; i < H_ACT*V_ACT; i++) prev_pix[i] = pix[i];
        capture_frame();
        diff = '0;
        for (int i = 0; i < H_ACT*V_ACT; i++) begin
            if (pix[i] !== prev_pix[i]) diff++;
        end
        check_coord("repeat frame mismatches", diff, '0);
        report("repeat frame", errs_before);
    endtask

    // reset lands where field pixel (1,3) is being registered, a star at every density
    task automatic reset_midframe();
        int errs_before;
        errs_before = errors;
        wait_vsync_end();
        repeat (4*H_TOT + 1) @(posedge clk_pix);     // outputs now two lines into the field
        rst_n <= 1'b0;
        repeat (3) begin
            @(negedge clk_pix);
            check_level("vga_de", vga_de, 1'b0);
            check_level("vga_hsync", vga_hsync, 1'b1);
            check_level("vga_vsync", vga_vsync, 1'b1);
            check_color("vga_r", vga_r, '0);
        end
        @(posedge clk_pix);
        rst_n <= 1'b1;
        report("mid-frame reset", errs_before);
    endtask

    initial begin
        clk_pix  = 1'b0;
        rst_n    = 1'b1;
        field_en = 1'b0;
        density  = '0;
        errors   = 0;
        passes   = 0;
        fails    = 0;
        cycles   = 0;
        // records plus repeat and rerun, each up to gap + settle + capture
        limit = ((NUM_TESTS + 2) * 7 + 2) * FRAME;
        void'($urandom(32'h1cd5));
        $readmemh("testbench/starfield_tests.txt", tests_mem);
        #1 rst_n = 1'b0;     // falling edge for the async reset
        repeat (8) @(posedge clk_pix);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            repeat (($urandom % 4) * FRAME) @(posedge clk_pix);   // idle gap
            run_record(t);
            if (t == 1) repeat_frame();
        end
        reset_midframe();
        run_record(2);
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passes, fails, starfield_top_i.starfield_chk_i.fail_cnt);
        if (fails == 0 && errors == 0 && starfield_top_i.starfield_chk_i.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/starfield_tests.txt */
// per record: id, density, field_en, lit count, point count, then 8 points of x y colour
// lit count is the number of nonzero field pixels in one frame
00 0 0 00 8  00 00 0  03 00 0  15 01 0  01 03 0  10 05 0  13 07 0  14 00 0  1e 02 0
01 0 1 11 8  00 00 f  03 00 8  15 01 7  01 03 7  10 05 f  13 07 b  14 00 0  1e 02 0
02 1 1 0c 8  00 00 f  03 00 8  15 01 0  01 03 7  10 05 f  13 07 b  14 00 0  1e 02 0
03 2 1 09 8  00 00 f  03 00 8  15 01 0  01 03 7  10 05 0  13 07 b  14 00 0  1e 02 0
04 3 1 08 8  00 00 f  03 00 8  15 01 0  01 03 7  10 05 0  13 07 0  14 00 0  1e 02 0

/* filelist.f */
design/disp_pkg.sv
design/star_pkg.sv
design/display_timing.sv
design/star_lfsr.sv
design/star_shader.sv
design/starfield_top.sv
testbench/starfield_chk.sv
testbench/starfield_tb.sv

/* Bender.yml */
package:
  name: starfield

sources:
  - design/disp_pkg.sv
  - design/star_pkg.sv
  - design/display_timing.sv
  - design/star_lfsr.sv
  - design/star_shader.sv
  - design/starfield_top.sv
  - target: simulation
    files:
      - testbench/starfield_chk.sv
      - testbench/starfield_tb.sv
